// ==== afu_defines.svh ====
////////////////////
// Widths, queue depth and APB register map of the accelerator shell
// AFU_CMD_DEPTH must be a power of two
////////////////////
`ifndef AFU_DEFINES_SVH
`define AFU_DEFINES_SVH

`define AFU_APB_ADDR_W  8
`define AFU_APB_DATA_W  32
`define AFU_OPND_W      16
`define AFU_TAG_W       4
`define AFU_CMD_DEPTH   4

// Register offsets
`define AFU_REG_CTRL    8'h00
`define AFU_REG_ARG_A   8'h04
`define AFU_REG_ARG_B   8'h08
`define AFU_REG_LAUNCH  8'h0C
`define AFU_REG_STATUS  8'h10
`define AFU_REG_RESULT  8'h14
`define AFU_REG_RES_TAG 8'h18

`endif

// ==== bsp_pkg.sv ====
////////////////////
// Host side APB types
// Requests come from the host, responses from the design
////////////////////
`default_nettype none

`include "afu_defines.svh"

package bsp_pkg;

    typedef logic [`AFU_APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [`AFU_APB_DATA_W-1:0] apb_data_t;

    // Driven by the host
    typedef struct packed {
        apb_addr_t paddr;
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_data_t pwdata;
    } apb_req_t;

    // Driven by the register block
    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

endpackage : bsp_pkg

`default_nettype wire

// ==== kernel_pkg.sv ====
////////////////////
// Kernel command, result and state types
// All arithmetic wraps at the operand width
////////////////////
`default_nettype none

`include "afu_defines.svh"

package kernel_pkg;

    typedef logic [`AFU_OPND_W-1:0] opnd_t;
    typedef logic [`AFU_TAG_W-1:0] tag_t;
    // Holds 0 to AFU_CMD_DEPTH inclusive
    typedef logic [$clog2(`AFU_CMD_DEPTH+1)-1:0] level_t;

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_XOR = 2'd2,
        OP_MUL = 2'd3
    } kernel_op_e;

    typedef struct packed {
        kernel_op_e op;
        opnd_t      arg_a;
        opnd_t      arg_b;
        tag_t       tag;
    } kernel_cmd_t;

    typedef struct packed {
        opnd_t result;
        tag_t  tag;
    } kernel_res_t;

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_EXEC,
        ENG_MUL
    } engine_state_e;

endpackage : kernel_pkg

`default_nettype wire

// ==== bsp_csr.sv ====
////////////////////
// APB register block, zero wait states
// A launch into a full queue is dropped and answered with pslverr
////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "afu_defines.svh"

module bsp_csr (
    input  logic                    clk,
    input  logic                    rst_n,
    input  bsp_pkg::apb_req_t       apb_req,
    output bsp_pkg::apb_rsp_t       apb_rsp,
    output logic                    push_valid,
    output kernel_pkg::kernel_cmd_t push_cmd,
    input  logic                    full,
    input  kernel_pkg::level_t      level,
    output logic                    run_enable,
    input  logic                    done_valid,
    input  kernel_pkg::kernel_res_t done_res
);

    logic               access;
    logic               wr_access;
    logic               launch_wr;
    logic               addr_hit;
    bsp_pkg::apb_data_t rd_data;

    logic               ctrl_en;
    kernel_pkg::opnd_t  arg_a;
    kernel_pkg::opnd_t  arg_b;
    kernel_pkg::opnd_t  last_result;
    kernel_pkg::tag_t   last_tag;
    // Completed command count, STATUS bits 15:0
    logic [15:0]        done_cnt;

    assign access    = apb_req.psel && apb_req.penable;
    assign wr_access = access && apb_req.pwrite;
    assign launch_wr = wr_access && (apb_req.paddr == `AFU_REG_LAUNCH);

    // Address decode and read mux
    always_comb begin
        addr_hit = 1'b1;
        rd_data  = '0;
        case (apb_req.paddr)
            `AFU_REG_CTRL:    rd_data = bsp_pkg::apb_data_t'(ctrl_en);
            `AFU_REG_ARG_A:   rd_data = bsp_pkg::apb_data_t'(arg_a);
            `AFU_REG_ARG_B:   rd_data = bsp_pkg::apb_data_t'(arg_b);
            `AFU_REG_LAUNCH:  rd_data = '0;
            `AFU_REG_STATUS:  rd_data = bsp_pkg::apb_data_t'({level, done_cnt});
            `AFU_REG_RESULT:  rd_data = bsp_pkg::apb_data_t'(last_result);
            `AFU_REG_RES_TAG: rd_data = bsp_pkg::apb_data_t'(last_tag);
            default:          addr_hit = 1'b0;
        endcase
    end

    assign apb_rsp.prdata  = rd_data;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access && (!addr_hit || (launch_wr && full));

    // Command goes into the queue at the access edge
    assign push_valid = launch_wr && !full;

    always_comb begin
        push_cmd.op    = kernel_pkg::kernel_op_e'(apb_req.pwdata[1:0]);
        push_cmd.arg_a = arg_a;
        push_cmd.arg_b = arg_b;
        push_cmd.tag   = apb_req.pwdata[7:4];
    end

    assign run_enable = ctrl_en;

    // Host writable registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_en <= 1'b0;
            arg_a   <= '0;
            arg_b   <= '0;
        end else if (wr_access) begin
            case (apb_req.paddr)
                `AFU_REG_CTRL:  ctrl_en <= apb_req.pwdata[0];
                `AFU_REG_ARG_A: arg_a   <= apb_req.pwdata[`AFU_OPND_W-1:0];
                `AFU_REG_ARG_B: arg_b   <= apb_req.pwdata[`AFU_OPND_W-1:0];
                default: ;
            endcase
        end
    end

    // Completion capture from the kernel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_cnt    <= '0;
            last_result <= '0;
            last_tag    <= '0;
        end else if (done_valid) begin
            done_cnt    <= done_cnt + 1'b1;
            last_result <= done_res.result;
            last_tag    <= done_res.tag;
        end
    end

endmodule : bsp_csr

`default_nettype wire

// ==== kernel_cmd_fifo.sv ====
////////////////////
// First-word-fall-through command queue
// Depth from AFU_CMD_DEPTH, a power of two
////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "afu_defines.svh"

module kernel_cmd_fifo (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    push_valid,
    input  kernel_pkg::kernel_cmd_t push_cmd,
    output logic                    full,
    output kernel_pkg::level_t      level,
    output logic                    pop_valid,
    output kernel_pkg::kernel_cmd_t pop_cmd,
    input  logic                    pop_ready
);

    localparam int PTR_W = $clog2(`AFU_CMD_DEPTH);

    kernel_pkg::kernel_cmd_t mem [`AFU_CMD_DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    kernel_pkg::level_t      count;
    logic                    do_push;
    logic                    do_pop;

    assign full      = (count == kernel_pkg::level_t'(`AFU_CMD_DEPTH));
    assign pop_valid = (count != '0);
    assign level     = count;
    // Head entry is visible without a read strobe
    assign pop_cmd   = mem[rd_ptr];

    assign do_push = push_valid && !full;
    assign do_pop  = pop_valid && pop_ready;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_cmd;
        end
    end

    // Pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule : kernel_cmd_fifo

`default_nettype wire

// ==== kernel_engine.sv ====
////////////////////
// One command at a time, MUL by 16 shift-add steps
// Completion pulse is one cycle wide
////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "afu_defines.svh"

module kernel_engine (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    run_enable,
    input  logic                    pop_valid,
    input  kernel_pkg::kernel_cmd_t pop_cmd,
    output logic                    pop_ready,
    output logic                    done_valid,
    output kernel_pkg::kernel_res_t done_res
);

    localparam int STEP_W = $clog2(`AFU_OPND_W);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`AFU_OPND_W - 1);

    kernel_pkg::engine_state_e state;
    logic [STEP_W-1:0]         step;
    logic                      take;
    kernel_pkg::opnd_t         alu_res;
    kernel_pkg::opnd_t         mcand;
    kernel_pkg::opnd_t         mplier;
    kernel_pkg::opnd_t         acc;
    kernel_pkg::opnd_t         acc_next;
    kernel_pkg::opnd_t         res_q;
    kernel_pkg::tag_t          tag_q;

    // Hold off while a MUL completion is still on the output
    assign pop_ready = (state == kernel_pkg::ENG_IDLE) && run_enable && !done_valid;
    assign take      = pop_valid && pop_ready;

    // Single cycle ops, wrapping
    always_comb begin
        case (pop_cmd.op)
            kernel_pkg::OP_ADD: alu_res = pop_cmd.arg_a + pop_cmd.arg_b;
            kernel_pkg::OP_SUB: alu_res = pop_cmd.arg_a - pop_cmd.arg_b;
            kernel_pkg::OP_XOR: alu_res = pop_cmd.arg_a ^ pop_cmd.arg_b;
            default:            alu_res = '0;
        endcase
    end

    assign acc_next = mplier[0] ? acc + mcand : acc;
    assign done_res = '{result: res_q, tag: tag_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= kernel_pkg::ENG_IDLE;
            step       <= '0;
            done_valid <= 1'b0;
        end else begin
            done_valid <= 1'b0;
            case (state)
                kernel_pkg::ENG_IDLE: begin
                    if (take && pop_cmd.op == kernel_pkg::OP_MUL) begin
                        state <= kernel_pkg::ENG_MUL;
                        step  <= '0;
                    end else if (take) begin
                        state      <= kernel_pkg::ENG_EXEC;
                        done_valid <= 1'b1;
                    end
                end
                kernel_pkg::ENG_EXEC: state <= kernel_pkg::ENG_IDLE;
                kernel_pkg::ENG_MUL: begin
                    step <= step + 1'b1;
                    if (step == LAST_STEP) begin
                        state      <= kernel_pkg::ENG_IDLE;
                        done_valid <= 1'b1;
                    end
                end
                default: state <= kernel_pkg::ENG_IDLE;
            endcase
        end
    end

    // Datapath, low half of the product builds up in acc
    always_ff @(posedge clk) begin
        if (take) begin
            tag_q  <= pop_cmd.tag;
            res_q  <= alu_res;
            mcand  <= pop_cmd.arg_a;
            mplier <= pop_cmd.arg_b;
            acc    <= '0;
        end else if (state == kernel_pkg::ENG_MUL) begin
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            acc    <= acc_next;
            res_q  <= acc_next;
        end
    end

endmodule : kernel_engine

`default_nettype wire

// ==== afu.sv ====
////////////////////
// Accelerator shell top, single clock and reset
// Kernel starts paused until CTRL bit 0 is set
////////////////////
`timescale 1ns/1ns
`default_nettype none

module afu (
    input  logic              clk,
    input  logic              rst_n,
    input  bsp_pkg::apb_req_t apb_req,
    output bsp_pkg::apb_rsp_t apb_rsp
);

    logic                    push_valid;
    kernel_pkg::kernel_cmd_t push_cmd;
    logic                    full;
    kernel_pkg::level_t      level;
    logic                    pop_valid;
    kernel_pkg::kernel_cmd_t pop_cmd;
    logic                    pop_ready;
    logic                    run_enable;
    logic                    done_valid;
    kernel_pkg::kernel_res_t done_res;

    // Host registers, command producer
    bsp_csr u_bsp_csr (
        .clk,
        .rst_n,
        .apb_req,
        .apb_rsp,
        .push_valid,
        .push_cmd,
        .full,
        .level,
        .run_enable,
        .done_valid,
        .done_res
    );

    kernel_cmd_fifo u_cmd_fifo (
        .clk,
        .rst_n,
        .push_valid,
        .push_cmd,
        .full,
        .level,
        .pop_valid,
        .pop_cmd,
        .pop_ready
    );

    kernel_engine u_kernel (
        .clk,
        .rst_n,
        .run_enable,
        .pop_valid,
        .pop_cmd,
        .pop_ready,
        .done_valid,
        .done_res
    );

endmodule : afu

`default_nettype wire

// ==== tb_clk_gen.sv ====
////////////////////
// Free running clock, reset held low for RESET_CYCLES rising edges
////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release lines up with a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule : tb_clk_gen

`default_nettype wire

// ==== afu_chk.sv ====
////////////////////
// Protocol assertions, bound into afu
// Inactive while rst_n is low
////////////////////
`timescale 1ns/1ns
`default_nettype none

module afu_chk (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire bsp_pkg::apb_req_t apb_req,
    input  wire bsp_pkg::apb_rsp_t apb_rsp,
    input  wire logic              push_valid,
    input  wire logic              full,
    input  wire logic              done_valid
);

    // Error response belongs to the access phase only
    pslverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
        else $error("pslverr raised outside an APB access phase");

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        push_valid |-> !full)
        else $error("queue push attempted while full");

    // Completion is a single cycle pulse
    done_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done_valid |=> !done_valid)
        else $error("done_valid high on two cycles in a row");

endmodule : afu_chk

bind afu afu_chk u_afu_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .push_valid (push_valid),
    .full       (full),
    .done_valid (done_valid)
);

`default_nettype wire

// ==== tb_afu.sv ====
////////////////////
// Table driven testbench, APB host with zero wait states
// Run length bounded by a cycle counter
////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "afu_defines.svh"

module tb_afu;

    localparam int NUM_STIM       = 8;
    localparam int TIMEOUT_CYCLES = NUM_STIM * 40 + 200;

    typedef struct packed {
        kernel_pkg::kernel_op_e op;
        kernel_pkg::opnd_t      arg_a;
        kernel_pkg::opnd_t      arg_b;
        kernel_pkg::tag_t       tag;
        kernel_pkg::opnd_t      expected;
    } stim_t;

    logic              clk;
    logic              rst_n;
    bsp_pkg::apb_req_t apb_req;
    bsp_pkg::apb_rsp_t apb_rsp;

    stim_t       stim [NUM_STIM];
    int          errors       = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycle_cnt    = 0;
    int unsigned exp_count    = 0;

    tb_clk_gen #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (3)
    ) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    afu DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    // Wrapping 16-bit arithmetic, MUL keeps the low half
    function automatic kernel_pkg::opnd_t calc_expected(input stim_t s);
        logic [2*`AFU_OPND_W-1:0] prod;
        prod = {16'd0, s.arg_a} * {16'd0, s.arg_b};
        case (s.op)
            kernel_pkg::OP_ADD: return s.arg_a + s.arg_b;
            kernel_pkg::OP_SUB: return s.arg_a - s.arg_b;
            kernel_pkg::OP_XOR: return s.arg_a ^ s.arg_b;
            default:            return prod[`AFU_OPND_W-1:0];
        endcase
    endfunction

    function automatic void build_table();
        stim[0] = '{kernel_pkg::OP_ADD, 16'hFFFF, 16'h0001, 4'h1, 16'h0};
        stim[1] = '{kernel_pkg::OP_SUB, 16'h0000, 16'h0001, 4'h2, 16'h0};
        stim[2] = '{kernel_pkg::OP_XOR, 16'hA5A5, 16'hFFFF, 4'h3, 16'h0};
        stim[3] = '{kernel_pkg::OP_MUL, 16'hFFFF, 16'hFFFF, 4'h4, 16'h0};
        for (int i = 4; i < NUM_STIM; i++) begin
            stim[i].op    = kernel_pkg::kernel_op_e'(i[1:0]);
            stim[i].arg_a = kernel_pkg::opnd_t'($urandom);
            stim[i].arg_b = kernel_pkg::opnd_t'($urandom);
            stim[i].tag   = kernel_pkg::tag_t'(i + 1);
        end
        for (int i = 0; i < NUM_STIM; i++) begin
            stim[i].expected = calc_expected(stim[i]);
        end
    endfunction

    // Setup edge, access edge, sample mid access phase, then idle
    task automatic apb_access(input bsp_pkg::apb_addr_t addr, input logic write,
                              input bsp_pkg::apb_data_t wdata,
                              output bsp_pkg::apb_data_t rdata, output logic err);
        bsp_pkg::apb_req_t req;
        req        = '0;
        req.paddr  = addr;
        req.psel   = 1'b1;
        req.pwrite = write;
        req.pwdata = wdata;
        @(posedge clk);
        apb_req <= req;
        req.penable = 1'b1;
        @(posedge clk);
        apb_req <= req;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        // Zero wait states, pready high in every access phase
        if (apb_rsp.pready !== 1'b1) begin
            mismatch("pready", {31'd0, apb_rsp.pready}, 32'h1);
        end
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic launch_cmd(input stim_t s, input kernel_pkg::tag_t tag, output logic err);
        bsp_pkg::apb_data_t rdata;
        apb_access(`AFU_REG_ARG_A, 1'b1, {16'd0, s.arg_a}, rdata, err);
        apb_access(`AFU_REG_ARG_B, 1'b1, {16'd0, s.arg_b}, rdata, err);
        apb_access(`AFU_REG_LAUNCH, 1'b1, {24'd0, tag, 2'b00, s.op}, rdata, err);
    endtask

    task automatic wait_done_count(input int unsigned target);
        bsp_pkg::apb_data_t rdata;
        logic               err;
        rdata = '0;
        while (rdata[15:0] != target[15:0]) begin
            apb_access(`AFU_REG_STATUS, 1'b0, '0, rdata, err);
        end
    endtask

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
        errors++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s", name);
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a command never completed", cycle_cnt);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        int                 errs_before;
        logic               err;
        bsp_pkg::apb_data_t rdata;
        bsp_pkg::apb_data_t snap [4];
        bsp_pkg::apb_addr_t snap_addr [4];
        apb_req = '0;
        void'($urandom(35));
        build_table();
        wait (rst_n === 1'b1);

        errs_before = errors;
        apb_access(`AFU_REG_STATUS, 1'b0, '0, rdata, err);
        if (rdata !== 32'h0) mismatch("STATUS", rdata, 32'h0);
        apb_access(`AFU_REG_RESULT, 1'b0, '0, rdata, err);
        if (rdata !== 32'h0) mismatch("RESULT", rdata, 32'h0);
        apb_access(`AFU_REG_CTRL, 1'b0, '0, rdata, err);
        if (rdata !== 32'h0) mismatch("CTRL", rdata, 32'h0);
        finish_test("reset values", errs_before);

        // One command in flight at a time
        apb_access(`AFU_REG_CTRL, 1'b1, 32'h1, rdata, err);
        for (int i = 0; i < NUM_STIM; i++) begin
            errs_before = errors;
            launch_cmd(stim[i], stim[i].tag, err);
            if (err) begin
                $display("Launch of table entry %0d was refused", i);
                errors++;
            end
            exp_count++;
            wait_done_count(exp_count);
            apb_access(`AFU_REG_RESULT, 1'b0, '0, rdata, err);
            if (rdata !== {16'd0, stim[i].expected}) begin
                mismatch("RESULT", rdata, {16'd0, stim[i].expected});
            end
            apb_access(`AFU_REG_RES_TAG, 1'b0, '0, rdata, err);
            if (rdata !== {28'd0, stim[i].tag}) mismatch("RES_TAG", rdata, {28'd0, stim[i].tag});
            finish_test($sformatf("single command %0d", i), errs_before);
        end

        // Kernel paused, fill the queue
        errs_before = errors;
        apb_access(`AFU_REG_CTRL, 1'b1, 32'h0, rdata, err);
        for (int i = 0; i < `AFU_CMD_DEPTH; i++) begin
            launch_cmd(stim[i], kernel_pkg::tag_t'(8 + i), err);
            if (err) begin
                $display("Launch %0d into a non-full queue was refused", i);
                errors++;
            end
        end
        apb_access(`AFU_REG_STATUS, 1'b0, '0, rdata, err);
        if (rdata[18:16] !== 3'd4) mismatch("STATUS.level", {29'd0, rdata[18:16]}, 32'd4);
        if (rdata[15:0] !== exp_count[15:0]) begin
            mismatch("STATUS.count", {16'd0, rdata[15:0]}, {16'd0, exp_count[15:0]});
        end
        launch_cmd(stim[4], 4'hF, err);
        if (!err) begin
            $display("Launch into a full queue returned no pslverr");
            errors++;
        end
        finish_test("full queue", errs_before);

        errs_before = errors;
        apb_access(`AFU_REG_CTRL, 1'b1, 32'h1, rdata, err);
        exp_count += `AFU_CMD_DEPTH;
        wait_done_count(exp_count);
        apb_access(`AFU_REG_STATUS, 1'b0, '0, rdata, err);
        if (rdata[18:16] !== 3'd0) mismatch("STATUS.level", {29'd0, rdata[18:16]}, 32'd0);
        apb_access(`AFU_REG_RES_TAG, 1'b0, '0, rdata, err);
        if (rdata !== 32'hB) mismatch("RES_TAG", rdata, 32'hB);
        apb_access(`AFU_REG_RESULT, 1'b0, '0, rdata, err);
        if (rdata !== {16'd0, stim[3].expected}) begin
            mismatch("RESULT", rdata, {16'd0, stim[3].expected});
        end
        finish_test("drain order", errs_before);

        // Unmapped offset must leave every register alone
        errs_before  = errors;
        snap_addr[0] = `AFU_REG_CTRL;
        snap_addr[1] = `AFU_REG_STATUS;
        snap_addr[2] = `AFU_REG_RESULT;
        snap_addr[3] = `AFU_REG_RES_TAG;
        for (int i = 0; i < 4; i++) begin
            apb_access(snap_addr[i], 1'b0, '0, snap[i], err);
        end
        apb_access(8'h40, 1'b0, '0, rdata, err);
        if (!err) begin
            $display("Read of unmapped offset 0x40 returned no pslverr");
            errors++;
        end
        for (int i = 0; i < 4; i++) begin
            apb_access(snap_addr[i], 1'b0, '0, rdata, err);
            if (rdata !== snap[i]) mismatch($sformatf("reg 0x%0h", snap_addr[i]), rdata, snap[i]);
        end
        finish_test("unmapped address", errs_before);

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tb_afu

`default_nettype wire

// ==== project.f ====
+incdir+.
bsp_pkg.sv
kernel_pkg.sv
bsp_csr.sv
kernel_cmd_fifo.sv
kernel_engine.sv
afu.sv
tb_clk_gen.sv
afu_chk.sv
tb_afu.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_afu \
		-f project.f -Mdir obj_dir -o Vtb_afu
	./obj_dir/Vtb_afu | tee $(LOG)
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG) || (echo "Simulation failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
